//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_system_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Finished with errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
+incdir+verilog
verilog/cpu_types_pkg.sv
verilog/mem_port_if.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/memory_arbiter.sv
verilog/unified_ram.sv
verilog/cpu_system.sv
testbench/cpu_system_assert.sv
testbench/cpu_system_tb.sv

//--- testbench/cpu_system_assert.sv
// arbiter and halt assertions
`timescale 1ns/1ns

module cpu_system_assert (
  input logic CLK,
  input logic nRST,
  input logic ram_ren,
  input logic ram_wen,
  input logic i_ren,
  input logic i_hit,
  input logic d_ren,
  input logic d_wen,
  input logic d_hit,
  input logic halt
);
  // one kind of access at a time
  ram_single_op: assert property (@(posedge CLK) disable iff (!nRST) !(ram_ren && ram_wen))
    else $error("ram saw read and write together");

  // hit only toward a requesting port
  i_hit_req: assert property (@(posedge CLK) disable iff (!nRST) i_hit |-> i_ren)
    else $error("instruction hit without request");
  d_hit_req: assert property (@(posedge CLK) disable iff (!nRST) d_hit |-> (d_ren || d_wen))
    else $error("data hit without request");

  // requests held until served
  i_req_held: assert property (@(posedge CLK) disable iff (!nRST) (i_ren && !i_hit) |=> i_ren)
    else $error("instruction request dropped before hit");
  d_req_held: assert property (@(posedge CLK) disable iff (!nRST)
                               (d_ren && !d_hit) |=> d_ren)
    else $error("data read dropped before hit");
  d_wr_held: assert property (@(posedge CLK) disable iff (!nRST)
                              (d_wen && !d_hit) |=> d_wen)
    else $error("data write dropped before hit");

  // sticky halt
  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt fell without reset");
endmodule

// signals not visible in a target are held low
bind memory_arbiter cpu_system_assert arb_assert_inst (
  .CLK, .nRST,
  .ram_ren(ramport.ren), .ram_wen(ramport.wen),
  .i_ren(iport.ren), .i_hit(iport.hit),
  .d_ren(dport.ren), .d_wen(dport.wen), .d_hit(dport.hit),
  .halt(1'b0)
);

bind datapath cpu_system_assert halt_assert_inst (
  .CLK, .nRST,
  .ram_ren(1'b0), .ram_wen(1'b0),
  .i_ren(1'b0), .i_hit(1'b0),
  .d_ren(1'b0), .d_wen(1'b0), .d_hit(1'b0),
  .halt
);

//--- testbench/cpu_system_tb.sv
// processor system testbench
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_system_tb;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int MODEL_STEPS = 256;
  // word indices of the data region and the register dump
  localparam int DATA_BASE = 64;
  localparam int DATA_WORDS = 16;
  localparam int DUMP_BASE = 96;

  logic CLK;
  logic nRST;
  logic prog_wen;
  cpu_types_pkg::word_t prog_addr;
  cpu_types_pkg::word_t prog_data;
  cpu_types_pkg::word_t dbg_addr;
  cpu_types_pkg::word_t dbg_rdata;
  logic halt;

  // ram image for the current test and the model state
  cpu_types_pkg::word_t image [`RAM_WORDS];
  cpu_types_pkg::word_t model_mem [`RAM_WORDS];
  cpu_types_pkg::word_t model_reg [32];
  cpu_types_pkg::word_t prog [$];
  string test_name;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;

  cpu_system cpu_system_inst (
    .CLK, .nRST,
    .prog_wen, .prog_addr, .prog_data,
    .dbg_addr, .dbg_rdata,
    .halt
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  task automatic check_word(input string what, input cpu_types_pkg::word_t expected,
                            input cpu_types_pkg::word_t actual);
    if (actual !== expected)
    begin
      $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_halt(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("error %s: %s expected %b actual %b", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // instruction encodings
  task automatic emit_r(input cpu_types_pkg::funct_t fn, input cpu_types_pkg::reg_addr_t rd,
                        input cpu_types_pkg::reg_addr_t rs, input cpu_types_pkg::reg_addr_t rt);
    prog.push_back({cpu_types_pkg::RTYPE, rs, rt, rd, 5'h00, fn});
  endtask

  task automatic emit_i(input cpu_types_pkg::opcode_t op, input cpu_types_pkg::reg_addr_t rt,
                        input cpu_types_pkg::reg_addr_t rs, input logic [15:0] imm);
    prog.push_back({op, rs, rt, imm});
  endtask

  function automatic logic [15:0] data_addr(input int w);
    return 16'(w * 4);
  endfunction

  // dump r1..r7, then stop
  task automatic finish_program();
    for (int r = 1; r < 8; r++)
      emit_i(cpu_types_pkg::SW, 5'(r), 5'd0, data_addr(DUMP_BASE + r - 1));
    prog.push_back({cpu_types_pkg::HALT, 26'h0});
  endtask

  task automatic random_program();
    int kind;
    cpu_types_pkg::reg_addr_t a;
    cpu_types_pkg::reg_addr_t b;
    cpu_types_pkg::reg_addr_t c;
    for (int i = 0; i < 30; i++)
    begin
      kind = $urandom_range(0, 7);
      a = 5'($urandom_range(1, 7));
      b = 5'($urandom_range(1, 7));
      c = 5'($urandom_range(1, 7));
      case (kind)
        0: emit_r(cpu_types_pkg::ADDU, a, b, c);
        1: emit_r(cpu_types_pkg::SUBU, a, b, c);
        2: emit_r(cpu_types_pkg::AND, a, b, c);
        3: emit_r(cpu_types_pkg::OR, a, b, c);
        4: emit_i(cpu_types_pkg::ADDIU, a, b, 16'($urandom));
        5: emit_i(cpu_types_pkg::LUI, a, 5'd0, 16'($urandom));
        6: emit_i(cpu_types_pkg::LW, a, 5'd0, data_addr(DATA_BASE + $urandom_range(0, 15)));
        default: emit_i(cpu_types_pkg::SW, a, 5'd0, data_addr(DATA_BASE + $urandom_range(0, 15)));
      endcase
    end
    finish_program();
  endtask

  // background fill, then the program from word zero
  task automatic build_image();
    for (int w = 0; w < `RAM_WORDS; w++)
      image[w] = 32'hd0d00000 + w;
    foreach (prog[i])
      image[i] = prog[i];
  endtask

  // one instruction at a time, straight from the instruction rules
  task automatic run_model();
    int pc;
    int steps;
    logic done;
    cpu_types_pkg::word_t ins;
    cpu_types_pkg::word_t simm;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t b;
    cpu_types_pkg::word_t ea;
    for (int i = 0; i < 32; i++)
      model_reg[i] = '0;
    for (int i = 0; i < `RAM_WORDS; i++)
      model_mem[i] = image[i];
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < MODEL_STEPS)
    begin
      ins = model_mem[pc];
      a = model_reg[ins[25:21]];
      b = model_reg[ins[20:16]];
      simm = {{16{ins[15]}}, ins[15:0]};
      ea = a + simm;
      case (ins[31:26])
        cpu_types_pkg::RTYPE:
        begin
          case (ins[5:0])
            cpu_types_pkg::ADDU: model_reg[ins[15:11]] = a + b;
            cpu_types_pkg::SUBU: model_reg[ins[15:11]] = a - b;
            cpu_types_pkg::AND:  model_reg[ins[15:11]] = a & b;
            cpu_types_pkg::OR:   model_reg[ins[15:11]] = a | b;
            default: ;
          endcase
        end
        cpu_types_pkg::ADDIU: model_reg[ins[20:16]] = ea;
        cpu_types_pkg::LUI:   model_reg[ins[20:16]] = {ins[15:0], 16'h0000};
        cpu_types_pkg::LW:    model_reg[ins[20:16]] = model_mem[(ea >> 2) % `RAM_WORDS];
        cpu_types_pkg::SW:    model_mem[(ea >> 2) % `RAM_WORDS] = b;
        cpu_types_pkg::HALT:  done = 1'b1;
        default: ;
      endcase
      // r0 stays zero
      model_reg[0] = '0;
      pc++;
      steps++;
    end
  endtask

  task automatic run_dut();
    int cycles;
    @(negedge CLK);
    nRST = 1'b0;
    prog_wen = 1'b0;
    repeat (5) @(negedge CLK);
    check_halt("halt in reset", 1'b0, halt);
    // program load while still in reset
    for (int w = 0; w < `RAM_WORDS; w++)
    begin
      prog_wen = 1'b1;
      prog_addr = w * 4;
      prog_data = image[w];
      @(negedge CLK);
    end
    prog_wen = 1'b0;
    nRST = 1'b1;
    @(negedge CLK);
    check_halt("halt after reset", 1'b0, halt);
    cycles = 0;
    while (!halt && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt)
    begin
      $display("%s: halt did not rise within %0d cycles", test_name, TIMEOUT_CYCLES);
      test_errors++;
    end
  endtask

  task automatic read_word(input int w, output cpu_types_pkg::word_t data);
    @(negedge CLK);
    dbg_addr = w * 4;
    @(posedge CLK);
    data = dbg_rdata;
  endtask

  task automatic check_results(input logic dump_regs);
    cpu_types_pkg::word_t got;
    if (dump_regs)
    begin
      for (int r = 1; r < 8; r++)
      begin
        read_word(DUMP_BASE + r - 1, got);
        check_word($sformatf("r%0d", r), model_reg[r], got);
      end
    end
    for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++)
    begin
      read_word(w, got);
      check_word($sformatf("mem[%0d]", w), model_mem[w], got);
    end
    // sticky halt still up after the reads
    @(negedge CLK);
    check_halt("halt held", 1'b1, halt);
  endtask

  task automatic run_test(input string name, input logic dump_regs);
    test_name = name;
    test_errors = 0;
    build_image();
    run_model();
    run_dut();
    check_results(dump_regs);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0)
      $display("test %s: pass", name);
    else
    begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, test_errors);
    end
    prog.delete();
  endtask

  initial
  begin
    void'($urandom(27162));
    nRST = 1'b0;
    prog_wen = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    dbg_addr = '0;
    tests_run = 0;
    tests_failed = 0;
    total_errors = 0;

    prog.push_back({cpu_types_pkg::HALT, 26'h0});
    run_test("halt_only", 1'b0);

    // alu ops and immediates
    emit_i(cpu_types_pkg::ADDIU, 5'd1, 5'd0, 16'h1234);
    emit_i(cpu_types_pkg::ADDIU, 5'd2, 5'd0, 16'hfffb);
    emit_i(cpu_types_pkg::LUI, 5'd3, 5'd0, 16'habcd);
    emit_r(cpu_types_pkg::ADDU, 5'd4, 5'd1, 5'd2);
    emit_r(cpu_types_pkg::SUBU, 5'd5, 5'd3, 5'd1);
    emit_r(cpu_types_pkg::AND, 5'd6, 5'd3, 5'd5);
    emit_r(cpu_types_pkg::OR, 5'd7, 5'd4, 5'd6);
    finish_program();
    run_test("alu", 1'b1);

    // stores and loads fight fetch for the ram
    emit_i(cpu_types_pkg::ADDIU, 5'd1, 5'd0, 16'h0055);
    emit_i(cpu_types_pkg::LUI, 5'd2, 5'd0, 16'h1357);
    emit_i(cpu_types_pkg::SW, 5'd1, 5'd0, data_addr(64));
    emit_i(cpu_types_pkg::SW, 5'd2, 5'd0, data_addr(65));
    emit_i(cpu_types_pkg::LW, 5'd3, 5'd0, data_addr(64));
    emit_i(cpu_types_pkg::LW, 5'd4, 5'd0, data_addr(65));
    emit_i(cpu_types_pkg::LW, 5'd5, 5'd0, data_addr(70));
    emit_i(cpu_types_pkg::SW, 5'd3, 5'd0, data_addr(71));
    emit_r(cpu_types_pkg::ADDU, 5'd6, 5'd3, 5'd4);
    emit_i(cpu_types_pkg::LW, 5'd7, 5'd0, data_addr(71));
    finish_program();
    run_test("store_load", 1'b1);

    // back to back dependences, load then use
    emit_i(cpu_types_pkg::ADDIU, 5'd1, 5'd0, 16'h0003);
    emit_r(cpu_types_pkg::ADDU, 5'd2, 5'd1, 5'd1);
    emit_r(cpu_types_pkg::SUBU, 5'd3, 5'd2, 5'd1);
    emit_i(cpu_types_pkg::LW, 5'd4, 5'd0, data_addr(66));
    emit_r(cpu_types_pkg::ADDU, 5'd5, 5'd4, 5'd3);
    emit_r(cpu_types_pkg::OR, 5'd6, 5'd5, 5'd2);
    emit_i(cpu_types_pkg::SW, 5'd6, 5'd0, data_addr(67));
    emit_i(cpu_types_pkg::LW, 5'd7, 5'd0, data_addr(67));
    emit_r(cpu_types_pkg::ADDU, 5'd7, 5'd7, 5'd6);
    finish_program();
    run_test("chain", 1'b1);

    for (int t = 0; t < 20; t++)
    begin
      random_program();
      run_test($sformatf("random_%0d", t), 1'b1);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end
endmodule

//--- verilog/control_unit.sv
// instruction decoder
`timescale 1ns/1ns

module control_unit (
  input  cpu_types_pkg::word_t instr,
  output cpu_types_pkg::control_t ctrl
);
  cpu_types_pkg::opcode_t op;
  cpu_types_pkg::funct_t fn;

  assign op = cpu_types_pkg::opcode_t'(instr[31:26]);
  assign fn = cpu_types_pkg::funct_t'(instr[5:0]);

  // anything unrecognised falls through as a nop
  always_comb
  begin
    ctrl = '0;
    case (op)
      cpu_types_pkg::RTYPE:
      begin
        ctrl.reg_dst = 1'b1;
        ctrl.reg_wr = 1'b1;
        case (fn)
          cpu_types_pkg::ADDU: ctrl.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: ctrl.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  ctrl.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   ctrl.aluop = cpu_types_pkg::ALU_OR;
          default:             ctrl.reg_wr = 1'b0;
        endcase
      end
      cpu_types_pkg::ADDIU:
      begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr = 1'b1;
      end
      // upper immediate added to zero
      cpu_types_pkg::LUI:
      begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr = 1'b1;
        ctrl.lui = 1'b1;
      end
      cpu_types_pkg::LW:
      begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_rd = 1'b1;
      end
      cpu_types_pkg::SW:
      begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_wr = 1'b1;
      end
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end
endmodule

//--- verilog/cpu_defines.svh
// processor sizing macros
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word width in bits
`define WORD_W 32

// architectural registers, r0 hardwired
`define REG_CNT 32

// byte address of first fetch after reset
`define PC_INIT 0

// unified ram depth in words
`define RAM_WORDS 256

// wait cycles before a ram access completes
`define RAM_LAT 2

`endif

//--- verilog/cpu_system.sv
// processor top level
`timescale 1ns/1ns

module cpu_system (
  input  logic CLK,
  input  logic nRST,
  // program load, used while in reset
  input  logic prog_wen,
  input  cpu_types_pkg::word_t prog_addr,
  input  cpu_types_pkg::word_t prog_data,
  // debug read
  input  cpu_types_pkg::word_t dbg_addr,
  output cpu_types_pkg::word_t dbg_rdata,
  output logic halt
);
  // fetch, data and shared ram ports
  mem_port_if iport ();
  mem_port_if dport ();
  mem_port_if ramport ();

  datapath datapath_inst (
    .CLK, .nRST,
    .iport(iport.master),
    .dport(dport.master),
    .halt
  );

  memory_arbiter arbiter_inst (
    .CLK, .nRST,
    .iport(iport.slave),
    .dport(dport.slave),
    .ramport(ramport.master)
  );

  unified_ram ram_inst (
    .CLK, .nRST,
    .ramport(ramport.slave),
    .prog_wen, .prog_addr, .prog_data,
    .dbg_addr, .dbg_rdata
  );
endmodule

//--- verilog/cpu_types_pkg.sv
// processor type package
`include "cpu_defines.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // primary opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    ADDIU = 6'h09,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25
  } funct_t;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR
  } aluop_t;

  // decoded control, travels down the pipeline
  typedef struct packed {
    aluop_t aluop;
    logic   alu_src;
    logic   reg_dst;
    logic   reg_wr;
    logic   mem_to_reg;
    logic   mem_rd;
    logic   mem_wr;
    logic   lui;
    logic   halt;
  } control_t;

  typedef enum logic [1:0] {
    IDLE,
    SERVE_I,
    SERVE_D
  } arb_state_t;

endpackage

//--- verilog/datapath.sv
// five stage pipelined datapath
`timescale 1ns/1ns
`include "cpu_defines.svh"

module datapath (
  input  logic CLK,
  input  logic nRST,
  mem_port_if.master iport,
  mem_port_if.master dport,
  output logic halt
);
  cpu_types_pkg::word_t pc, fd_instr, rdat1, rdat2, dec_imm, wb_data;
  cpu_types_pkg::word_t ex_rdat1, ex_rdat2, ex_imm, alu_a, alu_b, alu_out;
  cpu_types_pkg::word_t mem_alu, mem_store, wb_alu, wb_load;
  cpu_types_pkg::reg_addr_t rs, rt, rd, dec_wsel, ex_wsel, mem_wsel, wb_wsel;
  cpu_types_pkg::control_t dec_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
  logic fd_valid, ex_valid, mem_valid, wb_valid;
  logic mem_wait, ex_dep, mem_dep, hazard, stall, fd_next;
  logic dec_halt, halt_seen, fetch_req, wb_halt_q;

  // fetch side
  assign iport.ren = fetch_req;
  assign iport.wen = 1'b0;
  assign iport.addr = pc;
  assign iport.store = '0;

  // decode fields
  assign rs = fd_instr[25:21];
  assign rt = fd_instr[20:16];
  assign rd = fd_instr[15:11];
  assign dec_wsel = dec_ctrl.reg_dst ? rd : rt;
  assign dec_halt = fd_valid && dec_ctrl.halt;
  // lui moves the immediate up, everything else sign extends
  assign dec_imm = dec_ctrl.lui ? {fd_instr[15:0], 16'h0000} :
                                  {{16{fd_instr[15]}}, fd_instr[15:0]};

  control_unit ctrl_inst (.instr(fd_instr), .ctrl(dec_ctrl));

  register_file rf_inst (
    .CLK, .nRST,
    .wen(wb_valid && wb_ctrl.reg_wr), .wsel(wb_wsel), .wdat(wb_data),
    .rsel1(rs), .rsel2(rt), .rdat1, .rdat2
  );

  // sources still owed by execute or memory
  assign ex_dep = ex_valid && ex_ctrl.reg_wr && ex_wsel != '0 &&
                  (ex_wsel == rs || ex_wsel == rt);
  assign mem_dep = mem_valid && mem_ctrl.reg_wr && mem_wsel != '0 &&
                   (mem_wsel == rs || mem_wsel == rt);
  assign hazard = fd_valid && (ex_dep || mem_dep);
  assign mem_wait = (dport.ren || dport.wen) && !dport.hit;
  assign stall = hazard || mem_wait;
  // nothing younger than a halt gets in
  assign fd_next = iport.hit && !halt_seen && !dec_halt;

  // alu, lui zeroes the first operand
  always_comb
  begin
    alu_a = ex_ctrl.lui ? '0 : ex_rdat1;
    alu_b = ex_ctrl.alu_src ? ex_imm : ex_rdat2;
    case (ex_ctrl.aluop)
      cpu_types_pkg::ALU_ADD: alu_out = alu_a + alu_b;
      cpu_types_pkg::ALU_SUB: alu_out = alu_a - alu_b;
      cpu_types_pkg::ALU_AND: alu_out = alu_a & alu_b;
      default:                alu_out = alu_a | alu_b;
    endcase
  end

  // memory stage request
  assign dport.ren = mem_valid && mem_ctrl.mem_rd;
  assign dport.wen = mem_valid && mem_ctrl.mem_wr;
  assign dport.addr = mem_alu;
  assign dport.store = mem_store;

  assign wb_data = wb_ctrl.mem_to_reg ? wb_load : wb_alu;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc <= `PC_INIT;
      fd_valid <= 1'b0;
      ex_valid <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid <= 1'b0;
      halt_seen <= 1'b0;
      fetch_req <= 1'b0;
      wb_halt_q <= 1'b0;
      halt <= 1'b0;
    end
    else
    begin
      if (fd_next && !stall)
        pc <= pc + 32'd4;
      if (!stall)
        fd_valid <= fd_next;
      // bubble into execute on a hazard
      if (!mem_wait)
      begin
        ex_valid <= fd_valid && !hazard;
        mem_valid <= ex_valid;
        wb_valid <= mem_valid;
      end
      if (dec_halt)
        halt_seen <= 1'b1;
      // drop the fetch request only once its hit is in
      if (iport.hit && (halt_seen || dec_halt))
        fetch_req <= 1'b0;
      else if (!halt_seen && !dec_halt)
        fetch_req <= 1'b1;
      // two stage sticky halt
      if (wb_valid && wb_ctrl.halt)
        wb_halt_q <= 1'b1;
      if (wb_halt_q)
        halt <= 1'b1;
    end
  end

  // latch payload, qualified by the valid bits
  always_ff @(posedge CLK)
  begin
    if (!stall)
      fd_instr <= iport.load;
    if (!mem_wait)
    begin
      ex_ctrl <= dec_ctrl;
      ex_wsel <= dec_wsel;
      ex_rdat1 <= rdat1;
      ex_rdat2 <= rdat2;
      ex_imm <= dec_imm;
      mem_ctrl <= ex_ctrl;
      mem_wsel <= ex_wsel;
      mem_alu <= alu_out;
      mem_store <= ex_rdat2;
      wb_ctrl <= mem_ctrl;
      wb_wsel <= mem_wsel;
      wb_alu <= mem_alu;
      wb_load <= dport.load;
    end
  end
endmodule

//--- verilog/mem_port_if.sv
// memory request port
`timescale 1ns/1ns

interface mem_port_if;
  // request levels, held by the master until hit
  logic ren;
  logic wen;
  cpu_types_pkg::word_t addr;
  cpu_types_pkg::word_t store;
  // slave response, load valid in the hit cycle
  cpu_types_pkg::word_t load;
  logic hit;

  modport master (
    output ren, wen, addr, store,
    input  load, hit
  );

  modport slave (
    input  ren, wen, addr, store,
    output load, hit
  );
endinterface

//--- verilog/memory_arbiter.sv
// instruction and data memory arbiter
`timescale 1ns/1ns

module memory_arbiter (
  input logic CLK,
  input logic nRST,
  mem_port_if.slave iport,
  mem_port_if.slave dport,
  mem_port_if.master ramport
);
  cpu_types_pkg::arb_state_t state, next_state;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= cpu_types_pkg::IDLE;
    else
      state <= next_state;
  end

  // data first, one access outstanding
  always_comb
  begin
    next_state = state;
    case (state)
      cpu_types_pkg::IDLE:
      begin
        if (dport.ren || dport.wen)
          next_state = cpu_types_pkg::SERVE_D;
        else if (iport.ren)
          next_state = cpu_types_pkg::SERVE_I;
      end
      default:
      begin
        if (ramport.hit)
          next_state = cpu_types_pkg::IDLE;
      end
    endcase
  end

  // forward the granted port, ram idle otherwise
  always_comb
  begin
    ramport.ren = 1'b0;
    ramport.wen = 1'b0;
    ramport.addr = '0;
    ramport.store = '0;
    if (state == cpu_types_pkg::SERVE_D)
    begin
      ramport.ren = dport.ren;
      ramport.wen = dport.wen;
      ramport.addr = dport.addr;
      ramport.store = dport.store;
    end
    else if (state == cpu_types_pkg::SERVE_I)
    begin
      ramport.ren = iport.ren;
      ramport.wen = iport.wen;
      ramport.addr = iport.addr;
      ramport.store = iport.store;
    end
  end

  // hit only to the granted side
  assign dport.hit = (state == cpu_types_pkg::SERVE_D) && ramport.hit;
  assign iport.hit = (state == cpu_types_pkg::SERVE_I) && ramport.hit;
  assign dport.load = ramport.load;
  assign iport.load = ramport.load;
endmodule

//--- verilog/register_file.sv
// register file
`timescale 1ns/1ns
`include "cpu_defines.svh"

module register_file (
  input  logic CLK,
  input  logic nRST,
  input  logic wen,
  input  cpu_types_pkg::reg_addr_t wsel,
  input  cpu_types_pkg::word_t wdat,
  input  cpu_types_pkg::reg_addr_t rsel1,
  input  cpu_types_pkg::reg_addr_t rsel2,
  output cpu_types_pkg::word_t rdat1,
  output cpu_types_pkg::word_t rdat2
);
  cpu_types_pkg::word_t regs [`REG_CNT];

  // r0 never written
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < `REG_CNT; i++)
        regs[i] <= '0;
    end
    else if (wen && wsel != '0)
      regs[wsel] <= wdat;
  end

  // same-cycle write passes straight to the read
  function automatic cpu_types_pkg::word_t read_port(cpu_types_pkg::reg_addr_t sel);
    if (sel == '0)
      return '0;
    else if (wen && sel == wsel)
      return wdat;
    return regs[sel];
  endfunction

  always_comb
  begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end
endmodule

//--- verilog/unified_ram.sv
// unified ram with fixed latency
`timescale 1ns/1ns
`include "cpu_defines.svh"

module unified_ram (
  input  logic CLK,
  input  logic nRST,
  mem_port_if.slave ramport,
  input  logic prog_wen,
  input  cpu_types_pkg::word_t prog_addr,
  input  cpu_types_pkg::word_t prog_data,
  input  cpu_types_pkg::word_t dbg_addr,
  output cpu_types_pkg::word_t dbg_rdata
);
  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_LAT + 2);

  cpu_types_pkg::word_t mem [`RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic req;

  assign req = ramport.ren || ramport.wen;
  // hit lands RAM_LAT+1 cycles after the request shows up
  assign ramport.hit = req && (wait_cnt == CNT_W'(`RAM_LAT + 1));

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      wait_cnt <= '0;
    else if (ramport.hit || !req)
      wait_cnt <= '0;
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  // word index from byte address
  always_ff @(posedge CLK)
  begin
    if (prog_wen)
      mem[prog_addr[IDX_W+1:2]] <= prog_data;
    else if (ramport.hit && ramport.wen)
      mem[ramport.addr[IDX_W+1:2]] <= ramport.store;
  end

  assign ramport.load = mem[ramport.addr[IDX_W+1:2]];
  assign dbg_rdata = mem[dbg_addr[IDX_W+1:2]];
endmodule
